//--- source/rv_pkg.sv
// ***********************************************************
// shared widths, control enums, opcode values and the stage
// structs of the three-stage integer pipeline.
// ***********************************************************
`default_nettype none

package rv_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] ir_t;
    typedef logic [4:0]  reg_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_t;

    typedef enum logic [2:0] {
        OP2_RS2, OP2_I_IMM, OP2_S_IMM, OP2_B_IMM, OP2_U_IMM, OP2_J_IMM, OP2_FOUR
    } op2_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {KIND_ALU, KIND_JUMP, KIND_BRANCH, KIND_NONE} kind_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
        alu_op_t  alu_op;
        kind_t    kind;
        logic     writes_rd;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        kind_t    kind;
        alu_op_t  alu_op;
        funct3_t  funct3;
        data_t    op1;
        data_t    op2;
        data_t    rs1;       // register values for the branch compare.
        data_t    rs2;
        pc_t      pc;
        reg_t     rd;
        logic     writes_rd;
    } dec_t;

    typedef struct packed {
        logic     valid;
        kind_t    kind;
        reg_t     rd;
        logic     writes_rd;
        data_t    result;
        logic     taken;
        pc_t      target;
    } exe_t;

    typedef struct packed {
        logic     valid;
        reg_t     rd;
        data_t    data;
    } wb_t;

endpackage

`default_nettype wire

//--- source/control.sv
// ***********************************************************
// control decoder: opcode and function fields to operand
// selects, alu operation and instruction kind.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module control import rv_pkg::*; (
    input  ir_t   instr,
    output ctrl_t ctrl
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    reg_t    rd;
    alu_op_t func_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // register and immediate alu ops share the funct3 map.
    always_comb begin
        case (funct3)
            3'b000:  func_op = ALU_ADD;
            3'b001:  func_op = ALU_SLL;
            3'b010:  func_op = ALU_SLT;
            3'b011:  func_op = ALU_SLTU;
            3'b100:  func_op = ALU_XOR;
            3'b101:  func_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  func_op = ALU_OR;
            default: func_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl.op1_sel   = OP1_RS1;
        ctrl.op2_sel   = OP2_RS2;
        ctrl.alu_op    = ALU_ADD;
        ctrl.kind      = KIND_NONE;
        ctrl.writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : func_op;
                ctrl.kind      = KIND_ALU;
                ctrl.writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.op2_sel   = OP2_I_IMM;
                ctrl.alu_op    = func_op;    // no subtract form for immediates.
                ctrl.kind      = KIND_ALU;
                ctrl.writes_rd = 1'b1;
            end
            OPC_LUI: begin
                ctrl.op2_sel   = OP2_U_IMM;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.kind      = KIND_ALU;
                ctrl.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.op1_sel   = OP1_PC;
                ctrl.op2_sel   = OP2_U_IMM;
                ctrl.kind      = KIND_ALU;
                ctrl.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                ctrl.op1_sel   = OP1_PC;
                ctrl.op2_sel   = OP2_J_IMM;
                ctrl.kind      = KIND_JUMP;
                ctrl.writes_rd = 1'b1;
            end
            OPC_JALR: begin
                ctrl.op2_sel   = OP2_I_IMM;  // target is rs1 plus offset.
                ctrl.kind      = KIND_JUMP;
                ctrl.writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.op1_sel   = OP1_PC;
                ctrl.op2_sel   = OP2_B_IMM;
                ctrl.kind      = KIND_BRANCH;
            end
            default: ;                       // loads, stores, system act as no-ops.
        endcase
        if (rd == 5'd0) begin
            ctrl.writes_rd = 1'b0;           // x0 is never written.
        end
    end

endmodule

`default_nettype wire

//--- source/regfile.sv
// ***********************************************************
// register file: x1..x31, two read ports, write-through
// bypass from the writeback port.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_pkg::*; (
    input  logic  clk,
    input  reg_t  raddr1,
    input  reg_t  raddr2,
    output data_t rdata1,
    output data_t rdata2,
    input  wb_t   wb
);

    data_t regs [1:31];

    function automatic data_t read_port(input reg_t addr);
        data_t value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wb.valid && wb.rd == addr) begin
            value = wb.data;                 // value being written this cycle.
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- source/decode.sv
// ***********************************************************
// decode stage: immediates, operand forwarding and selection,
// and the decode pipeline register.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module decode import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  instr_valid,
    input  ir_t   instr,
    input  pc_t   instr_pc,
    input  ctrl_t ctrl,
    input  data_t rdata1,
    input  data_t rdata2,
    output reg_t  raddr1,
    output reg_t  raddr2,
    input  exe_t  exe_next,
    input  exe_t  exe,
    output dec_t  dec
);

    data_t i_imm, s_imm, b_imm, u_imm, j_imm;
    data_t rs1_val, rs2_val;
    data_t op2_mux;
    dec_t  dec_next;

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'd0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];

    // youngest producer wins; the register file bypass covers writeback.
    function automatic data_t forward(input reg_t addr, input data_t rf_value);
        data_t value;
        value = rf_value;
        if (addr != 5'd0) begin
            if (exe_next.valid && exe_next.writes_rd && exe_next.rd == addr) begin
                value = exe_next.result;
            end else if (exe.valid && exe.writes_rd && exe.rd == addr) begin
                value = exe.result;
            end
        end
        return value;
    endfunction

    always_comb begin
        rs1_val = forward(raddr1, rdata1);
        rs2_val = forward(raddr2, rdata2);
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2:   op2_mux = rs2_val;
            OP2_I_IMM: op2_mux = i_imm;
            OP2_S_IMM: op2_mux = s_imm;
            OP2_B_IMM: op2_mux = b_imm;
            OP2_U_IMM: op2_mux = u_imm;
            OP2_J_IMM: op2_mux = j_imm;
            default:   op2_mux = 32'd4;
        endcase
    end

    always_comb begin
        dec_next.valid     = instr_valid;
        dec_next.kind      = ctrl.kind;
        dec_next.alu_op    = ctrl.alu_op;
        dec_next.funct3    = instr[14:12];
        dec_next.op1       = (ctrl.op1_sel == OP1_PC) ? instr_pc : rs1_val;
        dec_next.op2       = op2_mux;
        dec_next.rs1       = rs1_val;
        dec_next.rs2       = rs2_val;
        dec_next.pc        = instr_pc;
        dec_next.rd        = instr[11:7];
        dec_next.writes_rd = ctrl.writes_rd;
    end

    always_ff @(posedge clk) begin
        dec <= dec_next;
        if (reset) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/execute.sv
// ***********************************************************
// execute stage: alu, branch compare, link value and the
// execute pipeline register.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module execute import rv_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  dec_t dec,
    output exe_t exe_next,
    output exe_t exe
);

    data_t      sum;
    data_t      alu;
    logic [4:0] shamt;
    logic       taken;

    assign sum   = dec.op1 + dec.op2;
    assign shamt = dec.op2[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu = sum;
            ALU_SUB:  alu = dec.op1 - dec.op2;
            ALU_SLL:  alu = dec.op1 << shamt;
            ALU_SLT:  alu = {31'd0, $signed(dec.op1) < $signed(dec.op2)};
            ALU_SLTU: alu = {31'd0, dec.op1 < dec.op2};
            ALU_XOR:  alu = dec.op1 ^ dec.op2;
            ALU_SRL:  alu = dec.op1 >> shamt;
            ALU_SRA:  alu = data_t'($signed(dec.op1) >>> shamt);
            ALU_OR:   alu = dec.op1 | dec.op2;
            ALU_AND:  alu = dec.op1 & dec.op2;
            default:  alu = dec.op2;         // lui passes the immediate.
        endcase
    end

    // compare uses the register values, not the selected operands.
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = dec.rs1 == dec.rs2;
            3'b001:  taken = dec.rs1 != dec.rs2;
            3'b100:  taken = $signed(dec.rs1) < $signed(dec.rs2);
            3'b101:  taken = $signed(dec.rs1) >= $signed(dec.rs2);
            3'b110:  taken = dec.rs1 < dec.rs2;
            3'b111:  taken = dec.rs1 >= dec.rs2;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        exe_next.valid     = dec.valid;
        exe_next.kind      = dec.kind;
        exe_next.rd        = dec.rd;
        exe_next.writes_rd = dec.writes_rd;
        exe_next.result    = alu;
        exe_next.taken     = 1'b0;
        exe_next.target    = sum;        // pc plus b immediate for branches.
        if (dec.kind == KIND_JUMP) begin
            exe_next.result = dec.pc + 32'd4;    // link value.
            exe_next.target = {sum[31:1], 1'b0}; // jalr clears bit 0.
        end
        if (dec.kind == KIND_BRANCH) begin
            exe_next.taken = taken;
        end
    end

    always_ff @(posedge clk) begin
        exe <= exe_next;
        if (reset) begin
            exe.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/result.sv
// ***********************************************************
// result stage: writeback register and branch report.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module result import rv_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  exe_t exe,
    output wb_t  wb,
    output logic br_valid,
    output logic br_taken,
    output pc_t  br_target
);

    logic is_flow;

    assign is_flow = exe.kind == KIND_JUMP || exe.kind == KIND_BRANCH;

    always_ff @(posedge clk) begin
        wb.valid  <= exe.valid && exe.writes_rd;
        wb.rd     <= exe.rd;
        wb.data   <= exe.result;
        br_valid  <= exe.valid && is_flow;
        br_taken  <= exe.kind == KIND_JUMP || exe.taken;  // jumps always taken.
        br_target <= exe.target;
        if (reset) begin
            wb.valid <= 1'b0;
            br_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/rv_core.sv
// ***********************************************************
// rv32i integer pipeline top: control decoder, register file,
// decode, execute and result stages.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  instr_valid,
    input  ir_t   instr,
    input  pc_t   instr_pc,
    output logic  wb_valid,
    output reg_t  wb_rd,
    output data_t wb_data,
    output logic  br_valid,
    output logic  br_taken,
    output pc_t   br_target
);

    ctrl_t ctrl;
    reg_t  raddr1, raddr2;
    data_t rdata1, rdata2;
    dec_t  dec;
    exe_t  exe_next, exe;
    wb_t   wb;

    control control_i (.instr(instr), .ctrl(ctrl));

    regfile regfile_i (
        .clk(clk), .raddr1(raddr1), .raddr2(raddr2),
        .rdata1(rdata1), .rdata2(rdata2), .wb(wb)
    );

    decode decode_i (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .instr_pc(instr_pc), .ctrl(ctrl), .rdata1(rdata1), .rdata2(rdata2),
        .raddr1(raddr1), .raddr2(raddr2), .exe_next(exe_next), .exe(exe),
        .dec(dec)
    );

    execute execute_i (
        .clk(clk), .reset(reset), .dec(dec), .exe_next(exe_next), .exe(exe)
    );

    result result_i (
        .clk(clk), .reset(reset), .exe(exe), .wb(wb),
        .br_valid(br_valid), .br_taken(br_taken), .br_target(br_target)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

//--- sim/rv_clock.sv
// ***********************************************************
// testbench clock, 20 ns period.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #10 clk = ~clk;    // half of the 20 ns period.

endmodule

`default_nettype wire

//--- sim/rv_core_assert.sv
// ***********************************************************
// concurrent checks on the pipeline's writeback and branch
// report ports, bound into the core.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert import rv_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  wb_valid,
    input reg_t  wb_rd,
    input data_t wb_data,
    input logic  br_valid
);

    // valid bits are cleared one edge into reset.
    idle_in_reset: assert property (@(posedge clk) reset |=> !wb_valid && !br_valid)
        else $error("writeback or branch report valid during reset");

    no_x0_write: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != 5'd0)
        else $error("writeback to x0");

    known_wb_data: assert property (
        @(posedge clk) disable iff (reset) wb_valid |-> !$isunknown(wb_data)
    ) else $error("writeback data has unknown bits");

endmodule

`default_nettype wire

//--- sim/rv_core_tb.sv
// ***********************************************************
// testbench for the rv32i pipeline: random instruction stream,
// in-order reference model, output checks and watchdog.
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int num_instr = 31 + 225 + 150 + 90 + 100 + 40 + 1;
    localparam int watchdog_cycles = 3 * num_instr + 100;   // gaps and drains included.

    logic  clk, reset, instr_valid;
    ir_t   instr;
    pc_t   instr_pc;
    logic  wb_valid, br_valid, br_taken;
    reg_t  wb_rd;
    data_t wb_data;
    pc_t   br_target;

    typedef struct packed {
        logic [31:0] cycle;    // edge count at which the outputs are due.
        logic        wb;
        reg_t        rd;
        data_t       data;
        logic        br;
        logic        taken;
        pc_t         target;
    } expect_t;

    expect_t exp_q [$];
    data_t   model_regs [0:31];
    pc_t     pc;
    integer  seed = 32'hdfe4_7d05;
    int      cycle_count = 0;
    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    int      errors_at_start;
    int      test_instr;
    string   test_name;
    funct3_t branch_codes [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    rv_clock clock_i (.clk(clk));

    rv_core rv_core_i (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .instr_pc(instr_pc), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .br_valid(br_valid), .br_taken(br_taken), .br_target(br_target)
    );

    bind rv_core rv_core_assert rv_core_assert_i (
        .clk(clk), .reset(reset), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_data(wb_data), .br_valid(br_valid)
    );

    always @(posedge clk) cycle_count = cycle_count + 1;

    function automatic ir_t r_word(funct7_t f7, reg_t rs2, reg_t rs1, funct3_t f3, reg_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic ir_t i_word(logic [11:0] imm, reg_t rs1, funct3_t f3, reg_t rd,
                                   opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic ir_t u_word(logic [19:0] imm, reg_t rd, opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic ir_t b_word(logic [12:0] imm, reg_t rs2, reg_t rs1, funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic ir_t j_word(logic [20:0] imm, reg_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic reg_t rand_reg();
        return reg_t'(($unsigned($random(seed)) % 31) + 1);   // x1..x31.
    endfunction

    // legal immediate for an op-imm funct3; shifts keep the upper bits clean.
    function automatic logic [11:0] imm_for(funct3_t f3);
        logic [11:0] imm;
        imm = 12'(rand32());
        if (f3 == 3'd1) begin
            imm[11:5] = 7'd0;
        end else if (f3 == 3'd5) begin
            imm[11:5] = {1'b0, imm[10], 5'd0};
        end
        return imm;
    endfunction

    function automatic data_t alu_model(funct3_t f3, logic alt, data_t a, data_t b);
        data_t r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = {31'd0, $signed(a) < $signed(b)};
            3'd3:    r = {31'd0, a < b};
            3'd4:    r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_model(funct3_t f3, data_t a, data_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // executes one instruction in order on the model registers.
    task automatic predict(input ir_t ins, input pc_t ipc, output expect_t e);
        data_t a, b, imm_i, res;
        logic  writes;
        a      = model_regs[ins[19:15]];
        b      = model_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        writes = 1'b1;
        res    = '0;
        e      = '0;
        e.cycle = cycle_count + 3;   // accepted next edge, outputs two edges later.
        case (opcode_t'(ins[6:0]))
            OPC_OP:     res = alu_model(ins[14:12], ins[30], a, b);
            OPC_OP_IMM: res = alu_model(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
            OPC_LUI:    res = {ins[31:12], 12'd0};
            OPC_AUIPC:  res = ipc + {ins[31:12], 12'd0};
            OPC_JAL: begin
                res      = ipc + 32'd4;
                e.br     = 1'b1;
                e.taken  = 1'b1;
                e.target = ipc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                res      = ipc + 32'd4;
                e.br     = 1'b1;
                e.taken  = 1'b1;
                e.target = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                writes   = 1'b0;
                e.br     = 1'b1;
                e.taken  = branch_model(ins[14:12], a, b);
                e.target = ipc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default:    writes = 1'b0;
        endcase
        e.wb   = writes && ins[11:7] != 5'd0;
        e.rd   = ins[11:7];
        e.data = res;
        if (e.wb) begin
            model_regs[ins[11:7]] = res;
        end
    endtask

    task automatic issue(input ir_t ins);
        expect_t e;
        predict(ins, pc, e);
        exp_q.push_back(e);
        instr_valid = 1'b1;
        instr       = ins;
        instr_pc    = pc;
        pc          = pc + 32'd4;
        test_instr++;
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        instr       = rand32();   // junk while idle must be ignored.
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic compare_data(input string what, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_reg(input string what, input reg_t expected, input reg_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_pc(input string what, input pc_t expected, input pc_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("ERROR in %s: %s at cycle %0d", test_name, msg, cycle_count);
    endtask

    task automatic check_outputs();
        expect_t e;
        e = '0;
        if (exp_q.size() != 0 && exp_q[0].cycle == cycle_count) begin
            e = exp_q.pop_front();
        end
        if (e.wb && wb_valid === 1'b1) begin
            compare_reg("wb_rd", e.rd, wb_rd);
            compare_data("wb_data", e.data, wb_data);
        end else if (e.wb) begin
            note_error("expected writeback did not appear");
        end else if (wb_valid !== 1'b0) begin
            note_error("writeback valid without a writing instruction");
        end
        if (e.br && br_valid === 1'b1) begin
            compare_flag("br_taken", e.taken, br_taken);
            compare_pc("br_target", e.target, br_target);
        end else if (e.br) begin
            note_error("expected branch report did not appear");
        end else if (br_valid !== 1'b0) begin
            note_error("branch report valid without a branch or jump");
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_outputs();
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        test_instr      = 0;
        tests++;
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(1);
        $display("%s: %0d instructions, %0d errors", test_name, test_instr,
                 errors - errors_at_start);
    endtask

    initial begin
        reg_t    rd, prev, prev2, rs1;
        funct3_t f3;
        logic    alt;
        int      k;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        pc          = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        start_test("reset_idle");
        idle(10);
        issue(i_word(12'h123, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        finish_test();

        start_test("init_regs");
        for (int r = 1; r < 32; r++) begin
            issue(i_word(12'(rand32()), 5'd0, 3'd0, reg_t'(r), OPC_OP_IMM));
        end
        finish_test();

        start_test("r_type");
        for (int n = 0; n < 200; n++) begin
            f3  = funct3_t'(rand32());
            alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand32()) : 1'b0;
            issue(r_word({1'b0, alt, 5'd0}, rand_reg(), rand_reg(), f3, rand_reg()));
            if (n % 8 == 0) begin
                issue(u_word(20'(rand32()), rand_reg(), OPC_LUI));   // wide operand values.
            end
        end
        finish_test();

        start_test("i_type");
        repeat (150) begin
            k  = $unsigned($random(seed)) % 8;
            f3 = funct3_t'(rand32());
            if (k == 0) begin
                issue(u_word(20'(rand32()), rand_reg(), OPC_LUI));
            end else if (k == 1) begin
                issue(u_word(20'(rand32()), rand_reg(), OPC_AUIPC));
            end else begin
                issue(i_word(imm_for(f3), rand_reg(), f3, rand_reg(), OPC_OP_IMM));
            end
        end
        finish_test();

        // each instruction reads the previous rd.
        start_test("dep_chain");
        for (int gap = 0; gap < 3; gap++) begin
            prev  = rand_reg();
            prev2 = rand_reg();
            repeat (30) begin
                rd = rand_reg();
                f3 = funct3_t'(rand32());
                if (1'(rand32())) begin
                    alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand32()) : 1'b0;
                    issue(r_word({1'b0, alt, 5'd0}, 1'(rand32()) ? prev2 : prev, prev, f3, rd));
                end else begin
                    issue(i_word(imm_for(f3), prev, f3, rd, OPC_OP_IMM));
                end
                idle(gap);
                prev2 = prev;
                prev  = rd;
            end
        end
        finish_test();

        start_test("branch_jump");
        repeat (100) begin
            k  = $unsigned($random(seed)) % 4;
            rd = reg_t'(rand32());   // x0 link is allowed here.
            if (k == 0) begin
                issue(j_word(21'(rand32()) & ~21'd1, rd));
            end else if (k == 1) begin
                issue(i_word(12'(rand32()), rand_reg(), 3'd0, rd, OPC_JALR));
            end else begin
                rs1 = rand_reg();
                f3  = branch_codes[$unsigned($random(seed)) % 6];
                issue(b_word(13'(rand32()) & ~13'd1, 1'(rand32()) ? rs1 : rand_reg(), rs1, f3));
            end
        end
        finish_test();

        start_test("x0_writes");
        repeat (10) begin
            issue(r_word(7'd0, rand_reg(), rand_reg(), 3'd0, 5'd0));
            issue(i_word(12'(rand32()), 5'd0, 3'd0, rand_reg(), OPC_OP_IMM));
            issue(i_word(12'(rand32()), rand_reg(), 3'd0, 5'd0, OPC_OP_IMM));
            issue(r_word(7'd0, 5'd0, 5'd0, 3'd6, rand_reg()));
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * 20);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/rv_pkg.sv
source/control.sv
source/regfile.sv
source/decode.sv
source/execute.sv
source/result.sv
source/rv_core.sv
sim/rv_clock.sv
sim/rv_core_assert.sv
sim/rv_core_tb.sv
